// File: design/fetchPkg.sv
// **************************************************
// Fetch-stage types shared across the core
// **************************************************

package fetchPkg;

    // Halfword offset inside an eight-halfword fetch block
    localparam int FETCH_OFF_W = 3;

    // Width of a halfword address
    localparam int HALF_PC_W = 31;

    typedef logic [HALF_PC_W-1:0] HalfPc_t;

    typedef logic [FETCH_OFF_W-1:0] FetchOff_t;

    // Predicted branch as handed to the fetch pipeline
    typedef struct packed {
        logic      valid;
        logic      isJump;
        // Compressed (16 bit) instruction
        logic      compr;
        // Position of the branch's last halfword
        FetchOff_t offs;
        HalfPc_t   dst;
    } PredBranch;

endpackage

// File: design/retAddrStack.sv
// **************************************************
// Circular return-address stack with wrapping index
// **************************************************

module retAddrStack (
    input  logic                     clk,
    input  logic                     rst,
    input  retPredPkg::StackCmd      stackCmd,
    output retPredPkg::RetStackIdx_t curIdx,
    output fetchPkg::HalfPc_t        topAddr
);
    import fetchPkg::*;
    import retPredPkg::*;

    HalfPc_t      ring [RET_STACK_SIZE];
    RetStackIdx_t idxQ;

    assign curIdx  = idxQ;
    assign topAddr = ring[idxQ];

    // Index update
    always_ff @(posedge clk) begin
        if (rst) begin
            idxQ <= '0;
        end else if (stackCmd.push || stackCmd.load) begin
            // Push moves to the slot it writes
            idxQ <= stackCmd.loadIdx;
        end else if (stackCmd.pop) begin
            // Wraps below zero
            idxQ <= idxQ - 1'b1;
        end
    end

    // Overwritten entries are simply lost
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RET_STACK_SIZE; i++) begin
                ring[i] <= '0;
            end
        end else if (stackCmd.push) begin
            ring[stackCmd.loadIdx] <= stackCmd.pushAddr;
        end
    end

    oneStackOp: assert property (@(posedge clk) disable iff (rst)
        $onehot0({stackCmd.push, stackCmd.pop, stackCmd.load}))
        else $error("Return stack got more than one operation");

endmodule

// File: design/retPredCtrl.sv
// **************************************************
// Return prediction control
// Picks the stack and table action and forms predBr
// **************************************************

module retPredCtrl (
    input  retPredPkg::ReturnDecUpd  returnUpd,
    input  logic                     fetchValid,
    input  fetchPkg::HalfPc_t        fetchPc,
    input  logic                     brValid,
    input  fetchPkg::FetchOff_t      brOffs,
    input  logic                     isCall,
    input  logic                     setIdx,
    input  retPredPkg::RetStackIdx_t restoreIdx,
    input  retPredPkg::RetStackIdx_t curIdx,
    input  fetchPkg::HalfPc_t        topAddr,
    input  retPredPkg::SiteHit       siteHit,
    output retPredPkg::StackCmd      stackCmd,
    output retPredPkg::SiteUpd       siteUpd,
    output fetchPkg::PredBranch      predBr
);
    import fetchPkg::*;
    import retPredPkg::*;

    logic    predValid;
    logic    predPop;
    logic    fetchCall;
    HalfPc_t fetchCallAddr;

    assign predValid = fetchValid && siteHit.hit;

    // Pop only if no earlier branch in the block takes over
    assign predPop = predValid && (!brValid || brOffs >= siteHit.offs);

    assign fetchCall = brValid && isCall;

    // Return address is the halfword after the call's last one
    assign fetchCallAddr = {fetchPc[HALF_PC_W-1:FETCH_OFF_W], brOffs} + 1'b1;

    always_comb begin
        predBr.valid  = predValid;
        predBr.isJump = 1'b1;
        predBr.compr  = predValid ? siteHit.compr : 1'b0;
        predBr.offs   = predValid ? siteHit.offs : '0;
        predBr.dst    = topAddr;
    end

    // Priority order is decode update, predicted return, fetch call, restore
    always_comb begin
        stackCmd = '0;
        siteUpd  = '0;

        if (returnUpd.valid) begin
            siteUpd.addr  = returnUpd.addr;
            siteUpd.compr = returnUpd.compr;
            siteUpd.clean = returnUpd.cleanRet;
            if (returnUpd.isCall) begin
                stackCmd.push     = 1'b1;
                stackCmd.loadIdx  = returnUpd.idx + 1'b1;
                stackCmd.pushAddr = returnUpd.addr + 1'b1;
            end else if (returnUpd.isRet) begin
                // Unpredicted return learns its site
                stackCmd.load    = 1'b1;
                stackCmd.loadIdx = returnUpd.idx - 1'b1;
                siteUpd.insert   = 1'b1;
            end
        end else if (predPop) begin
            stackCmd.pop     = 1'b1;
            siteUpd.markUsed = 1'b1;
            siteUpd.way      = siteHit.way;
            siteUpd.addr     = fetchPc;
        end else if (fetchCall) begin
            stackCmd.push     = 1'b1;
            stackCmd.loadIdx  = curIdx + 1'b1;
            stackCmd.pushAddr = fetchCallAddr;
        end

        // Restore only when nothing else moves the index
        if (setIdx && !stackCmd.push && !stackCmd.pop && !stackCmd.load) begin
            stackCmd.load    = 1'b1;
            stackCmd.loadIdx = restoreIdx;
        end
    end

    // Decode never classifies an instruction as both call and return
    callOrRet: assert final (!(returnUpd.valid && returnUpd.isCall && returnUpd.isRet))
        else $error("Decode update flags both call and return");

endmodule

// File: design/retPredPkg.sv
// **************************************************
// Sizes, types and address split of return prediction
// **************************************************

package retPredPkg;

    localparam int RET_STACK_SIZE = 4;
    localparam int RET_SITE_SETS  = 4;
    localparam int RET_SITE_WAYS  = 2;
    localparam int RET_SITE_TAG_W = 8;

    localparam int RET_STACK_IDX_W = $clog2(RET_STACK_SIZE);
    localparam int RET_SITE_SET_W  = $clog2(RET_SITE_SETS);
    localparam int RET_SITE_WAY_W  = $clog2(RET_SITE_WAYS);

    typedef logic [RET_STACK_IDX_W-1:0] RetStackIdx_t;
    typedef logic [RET_SITE_SET_W-1:0]  SiteSet_t;
    typedef logic [RET_SITE_WAY_W-1:0]  SiteWay_t;
    typedef logic [RET_SITE_TAG_W-1:0]  SiteTag_t;

    // Update sent by decode for calls and returns fetch did not predict
    typedef struct packed {
        logic             valid;
        logic             isCall;
        logic             isRet;
        logic             cleanRet;
        logic             compr;
        RetStackIdx_t     idx;
        fetchPkg::HalfPc_t addr;
    } ReturnDecUpd;

    typedef struct packed {
        logic                valid;
        logic                used;
        logic                compr;
        SiteTag_t            tag;
        fetchPkg::FetchOff_t offs;
    } RetSiteEntry;

    typedef struct packed {
        logic                hit;
        SiteWay_t            way;
        fetchPkg::FetchOff_t offs;
        logic                compr;
    } SiteHit;

    typedef struct packed {
        logic              insert;
        logic              clean;
        logic              markUsed;
        SiteWay_t          way;
        fetchPkg::HalfPc_t addr;
        logic              compr;
    } SiteUpd;

    // Push target and new index both travel in loadIdx
    typedef struct packed {
        logic              push;
        logic              pop;
        logic              load;
        RetStackIdx_t      loadIdx;
        fetchPkg::HalfPc_t pushAddr;
    } StackCmd;

    // Address split is offset, then set, then tag
    function automatic fetchPkg::FetchOff_t siteOffs(fetchPkg::HalfPc_t addr);
        return addr[fetchPkg::FETCH_OFF_W-1:0];
    endfunction

    function automatic SiteSet_t siteSet(fetchPkg::HalfPc_t addr);
        return addr[fetchPkg::FETCH_OFF_W +: RET_SITE_SET_W];
    endfunction

    function automatic SiteTag_t siteTag(fetchPkg::HalfPc_t addr);
        return addr[fetchPkg::FETCH_OFF_W + RET_SITE_SET_W +: RET_SITE_TAG_W];
    endfunction

endpackage

// File: design/retPredUnit.sv
// **************************************************
// Return prediction unit for the fetch stage
// **************************************************

module retPredUnit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetchValid,
    input  fetchPkg::HalfPc_t        fetchPc,
    input  logic                     brValid,
    input  fetchPkg::FetchOff_t      brOffs,
    input  logic                     isCall,
    input  logic                     setIdx,
    input  retPredPkg::RetStackIdx_t restoreIdx,
    input  retPredPkg::ReturnDecUpd  returnUpd,
    output retPredPkg::RetStackIdx_t curIdx,
    output fetchPkg::PredBranch      predBr
);
    import fetchPkg::*;
    import retPredPkg::*;

    SiteHit  siteHit;
    SiteUpd  siteUpd;
    StackCmd stackCmd;
    HalfPc_t topAddr;

    retSiteTable siteTable_i (
        .clk     (clk),
        .rst     (rst),
        .fetchPc (fetchPc),
        .siteUpd (siteUpd),
        .siteHit (siteHit)
    );

    retAddrStack addrStack_i (
        .clk      (clk),
        .rst      (rst),
        .stackCmd (stackCmd),
        .curIdx   (curIdx),
        .topAddr  (topAddr)
    );

    retPredCtrl ctrl_i (
        .returnUpd  (returnUpd),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .brValid    (brValid),
        .brOffs     (brOffs),
        .isCall     (isCall),
        .setIdx     (setIdx),
        .restoreIdx (restoreIdx),
        .curIdx     (curIdx),
        .topAddr    (topAddr),
        .siteHit    (siteHit),
        .stackCmd   (stackCmd),
        .siteUpd    (siteUpd),
        .predBr     (predBr)
    );

endmodule

// File: design/retSiteTable.sv
// **************************************************
// Set-associative table of return sites
// Finds the nearest recorded return in a fetch block
// **************************************************

module retSiteTable (
    input  logic               clk,
    input  logic               rst,
    input  fetchPkg::HalfPc_t  fetchPc,
    input  retPredPkg::SiteUpd siteUpd,
    output retPredPkg::SiteHit siteHit
);
    import fetchPkg::*;
    import retPredPkg::*;

    RetSiteEntry sites [RET_SITE_SETS][RET_SITE_WAYS];

    SiteSet_t    lookSet;
    SiteTag_t    lookTag;
    FetchOff_t   lookOffs;

    SiteSet_t    updSet;
    SiteTag_t    updTag;
    FetchOff_t   updOffs;

    logic        refreshHit;
    SiteWay_t    refreshWay;
    logic        freeFound;
    SiteWay_t    freeWay;
    logic        insDo;
    SiteWay_t    insWay;
    RetSiteEntry newEntry;

    assign lookSet  = siteSet(fetchPc);
    assign lookTag  = siteTag(fetchPc);
    assign lookOffs = siteOffs(fetchPc);

    assign updSet  = siteSet(siteUpd.addr);
    assign updTag  = siteTag(siteUpd.addr);
    assign updOffs = siteOffs(siteUpd.addr);

    // Smallest offs at or after the fetch offset wins
    always_comb begin
        siteHit = '0;
        for (int w = 0; w < RET_SITE_WAYS; w++) begin
            if (sites[lookSet][w].valid &&
                sites[lookSet][w].tag == lookTag &&
                sites[lookSet][w].offs >= lookOffs &&
                (!siteHit.hit || sites[lookSet][w].offs < siteHit.offs)) begin
                siteHit.hit   = 1'b1;
                siteHit.way   = SiteWay_t'(w);
                siteHit.offs  = sites[lookSet][w].offs;
                siteHit.compr = sites[lookSet][w].compr;
            end
        end
    end

    // An insert refreshes a matching site first,
    // else takes the lowest way that is free or not yet used
    always_comb begin
        refreshHit = 1'b0;
        refreshWay = '0;
        freeFound  = 1'b0;
        freeWay    = '0;
        for (int w = 0; w < RET_SITE_WAYS; w++) begin
            if (!refreshHit && sites[updSet][w].valid &&
                sites[updSet][w].tag == updTag &&
                sites[updSet][w].offs == updOffs) begin
                refreshHit = 1'b1;
                refreshWay = SiteWay_t'(w);
            end
            if (!freeFound && (!sites[updSet][w].valid || !sites[updSet][w].used)) begin
                freeFound = 1'b1;
                freeWay   = SiteWay_t'(w);
            end
        end
        insWay = refreshHit ? refreshWay : freeWay;
        insDo  = siteUpd.insert && (refreshHit || freeFound);
    end

    always_comb begin
        newEntry.valid = 1'b1;
        newEntry.used  = 1'b0;
        newEntry.compr = siteUpd.compr;
        newEntry.tag   = updTag;
        newEntry.offs  = updOffs;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < RET_SITE_SETS; s++) begin
                for (int w = 0; w < RET_SITE_WAYS; w++) begin
                    sites[s][w].valid <= 1'b0;
                    sites[s][w].used  <= 1'b0;
                end
            end
        end else begin
            if (siteUpd.clean) begin
                for (int w = 0; w < RET_SITE_WAYS; w++) begin
                    sites[updSet][w].valid <= 1'b0;
                end
            end
            // Written after the clean so the inserted way survives it
            if (insDo) begin
                sites[updSet][insWay] <= newEntry;
            end
            if (siteUpd.markUsed) begin
                sites[updSet][siteUpd.way].used <= 1'b1;
            end
        end
    end

    // Controller never mixes a decode insert with a fetch pop
    insertNotUsed: assert property (@(posedge clk) disable iff (rst)
        !(siteUpd.insert && siteUpd.markUsed))
        else $error("Site table got insert and markUsed together");

endmodule

// File: dv/retPredTb.sv
// **************************************************
// Testbench for the return prediction unit
// Applies a table of stimulus rows and checks each cycle
// **************************************************

module retPredTb;
    import fetchPkg::*;
    import retPredPkg::*;

    localparam int RESET_CYCLES  = 3;
    localparam int RESET_TIMEOUT = 20;

    // One cycle of stimulus and the response expected within that cycle
    typedef struct packed {
        logic         fetchValid;
        HalfPc_t      fetchPc;
        logic         brValid;
        FetchOff_t    brOffs;
        logic         isCall;
        logic         setIdx;
        RetStackIdx_t restoreIdx;
        ReturnDecUpd  returnUpd;
        RetStackIdx_t expIdx;
        PredBranch    expPred;
    } TestRow;

    localparam ReturnDecUpd NO_UPD  = '0;
    localparam PredBranch   NO_PRED = '0;

    logic         clk;
    logic         rst;
    logic         fetchValid;
    HalfPc_t      fetchPc;
    logic         brValid;
    FetchOff_t    brOffs;
    logic         isCall;
    logic         setIdx;
    RetStackIdx_t restoreIdx;
    ReturnDecUpd  returnUpd;
    RetStackIdx_t curIdx;
    PredBranch    predBr;

    TestRow rows [$];

    tbClock clock_i (.clk(clk));

    retPredUnit dut_i (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .brValid    (brValid),
        .brOffs     (brOffs),
        .isCall     (isCall),
        .setIdx     (setIdx),
        .restoreIdx (restoreIdx),
        .returnUpd  (returnUpd),
        .curIdx     (curIdx),
        .predBr     (predBr)
    );

    // Halfword address built from tag, set and offset
    function automatic HalfPc_t pcAt(int tag, int set, int offs);
        return HalfPc_t'({tag[7:0], set[1:0], offs[2:0]});
    endfunction

    function automatic ReturnDecUpd decodeUpd(logic call, logic ret, logic clean,
                                              logic compr, RetStackIdx_t idx, HalfPc_t addr);
        ReturnDecUpd u;
        u.valid    = 1'b1;
        u.isCall   = call;
        u.isRet    = ret;
        u.cleanRet = clean;
        u.compr    = compr;
        u.idx      = idx;
        u.addr     = addr;
        return u;
    endfunction

    function automatic PredBranch hitPred(FetchOff_t offs, logic compr, HalfPc_t dst);
        PredBranch p;
        p.valid  = 1'b1;
        p.isJump = 1'b1;
        p.compr  = compr;
        p.offs   = offs;
        p.dst    = dst;
        return p;
    endfunction

    task automatic addRow(input logic fv, input HalfPc_t pc, input logic bv, input FetchOff_t bo,
                          input logic call, input logic si, input RetStackIdx_t ri,
                          input ReturnDecUpd upd, input RetStackIdx_t eIdx,
                          input PredBranch ePred);
        rows.push_back(TestRow'{fv, pc, bv, bo, call, si, ri, upd, eIdx, ePred});
    endtask

    task automatic stopRun(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic reportValue(input int row, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("[FAIL] row %0d %s got 0x%0h expected 0x%0h", row, name, got, exp);
        stopRun($sformatf("Wrong value of %s in row %0d", name, row));
    endtask

    task automatic checkIdx(input int row, input RetStackIdx_t got, input RetStackIdx_t exp);
        if (got !== exp) begin
            reportValue(row, "curIdx", 32'(got), 32'(exp));
        end
    endtask

    // Target and jump flag only matter for a valid prediction
    task automatic checkPred(input int row, input PredBranch got, input PredBranch exp);
        if (got.valid !== exp.valid) begin
            reportValue(row, "predBr.valid", 32'(got.valid), 32'(exp.valid));
        end else if (got.offs !== exp.offs) begin
            reportValue(row, "predBr.offs", 32'(got.offs), 32'(exp.offs));
        end else if (got.compr !== exp.compr) begin
            reportValue(row, "predBr.compr", 32'(got.compr), 32'(exp.compr));
        end else if (exp.valid && got.isJump !== 1'b1) begin
            reportValue(row, "predBr.isJump", 32'(got.isJump), 32'(1'b1));
        end else if (exp.valid && got.dst !== exp.dst) begin
            reportValue(row, "predBr.dst", 32'(got.dst), 32'(exp.dst));
        end
    endtask

    // Each row holds fetchValid fetchPc brValid brOffs isCall setIdx restoreIdx returnUpd
    // and then the expected curIdx and predBr
    task automatic loadRows();
        addRow(1, pcAt('h34, 2, 0), 0, 0, 0, 0, 0, NO_UPD, 0, NO_PRED);
        // Decode call, decode return, restore, then two predicted pops
        addRow(0, '0, 0, 0, 0, 0, 0, decodeUpd(1, 0, 0, 0, 0, pcAt('h12, 1, 3)), 0, NO_PRED);
        addRow(0, '0, 0, 0, 0, 0, 0, decodeUpd(0, 1, 0, 1, 1, pcAt('h40, 2, 5)), 1, NO_PRED);
        addRow(0, '0, 0, 0, 0, 1, 1, NO_UPD, 0, NO_PRED);
        addRow(1, pcAt('h40, 2, 2), 0, 0, 0, 0, 0, NO_UPD, 1, hitPred(5, 1, pcAt('h12, 1, 4)));
        addRow(1, pcAt('h40, 2, 5), 0, 0, 0, 0, 0, NO_UPD, 0, hitPred(5, 1, '0));
        // Fetch call wraps the index back to 0
        addRow(1, pcAt('h21, 0, 0), 1, 6, 1, 0, 0, NO_UPD, 3, NO_PRED);
        addRow(1, pcAt('h40, 2, 6), 0, 0, 0, 0, 0, NO_UPD, 0, NO_PRED);
        addRow(1, pcAt('h40, 2, 1), 1, 3, 0, 0, 0, NO_UPD, 0, hitPred(5, 1, pcAt('h21, 0, 7)));
        addRow(1, pcAt('h40, 2, 0), 0, 0, 0, 0, 0, NO_UPD, 0, hitPred(5, 1, pcAt('h21, 0, 7)));
        // Several sites in set 3
        addRow(0, '0, 0, 0, 0, 0, 0, decodeUpd(0, 1, 0, 0, 3, pcAt('h77, 3, 6)), 3, NO_PRED);
        addRow(1, pcAt('h77, 3, 5), 0, 0, 0, 0, 0, NO_UPD, 2, hitPred(6, 0, '0));
        addRow(0, '0, 0, 0, 0, 0, 0, decodeUpd(0, 1, 0, 1, 1, pcAt('h77, 3, 2)), 1, NO_PRED);
        addRow(1, pcAt('h77, 3, 0), 1, 0, 0, 0, 0, NO_UPD, 0, hitPred(2, 1, pcAt('h21, 0, 7)));
        addRow(0, '0, 0, 0, 0, 0, 0, decodeUpd(0, 1, 0, 1, 0, pcAt('h77, 3, 4)), 0, NO_PRED);
        addRow(1, pcAt('h77, 3, 2), 1, 0, 0, 0, 0, NO_UPD, 3, hitPred(4, 1, '0));
        addRow(0, '0, 0, 0, 0, 0, 0, decodeUpd(0, 1, 0, 0, 3, pcAt('h77, 3, 6)), 3, NO_PRED);
        addRow(1, pcAt('h77, 3, 0), 1, 0, 0, 0, 0, NO_UPD, 2, hitPred(4, 1, '0));
        addRow(1, pcAt('h77, 3, 5), 1, 0, 0, 0, 0, NO_UPD, 2, hitPred(6, 0, '0));
        // Clean of set 3 leaves set 2 alone
        addRow(0, '0, 0, 0, 0, 0, 0, decodeUpd(0, 0, 1, 0, 2, pcAt('h77, 3, 0)), 2, NO_PRED);
        addRow(1, pcAt('h77, 3, 0), 0, 0, 0, 0, 0, NO_UPD, 2, NO_PRED);
        addRow(1, pcAt('h40, 2, 0), 1, 5, 0, 0, 0, NO_UPD, 2, hitPred(5, 1, '0));
        addRow(0, '0, 0, 0, 0, 0, 0, decodeUpd(0, 1, 1, 0, 1, pcAt('h40, 2, 1)), 1, NO_PRED);
        addRow(1, pcAt('h40, 2, 3), 0, 0, 0, 0, 0, NO_UPD, 0, NO_PRED);
        addRow(1, pcAt('h40, 2, 0), 1, 0, 0, 0, 0, NO_UPD, 0, hitPred(1, 0, pcAt('h21, 0, 7)));
        // Restore beside an idle fetch, then losing to a decode call and to a pop
        addRow(0, pcAt('h40, 2, 0), 0, 0, 0, 1, 2, NO_UPD, 0, NO_PRED);
        addRow(0, '0, 0, 0, 0, 1, 0, decodeUpd(1, 0, 0, 0, 2, pcAt('h5a, 1, 6)), 2, NO_PRED);
        addRow(1, pcAt('h40, 2, 0), 0, 0, 0, 1, 1, NO_UPD, 3, hitPred(1, 0, pcAt('h5a, 1, 7)));
        addRow(0, '0, 0, 0, 0, 0, 0, NO_UPD, 2, NO_PRED);
    endtask

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

    initial begin
        int waited;
        fetchValid = 1'b0;
        fetchPc    = '0;
        brValid    = 1'b0;
        brOffs     = '0;
        isCall     = 1'b0;
        setIdx     = 1'b0;
        restoreIdx = '0;
        returnUpd  = '0;
        loadRows();

        waited = 0;
        while (rst !== 1'b0) begin
            if (waited == RESET_TIMEOUT) begin
                stopRun("Reset was not released in time");
            end
            @(posedge clk);
            waited++;
        end

        foreach (rows[i]) begin
            fetchValid <= rows[i].fetchValid;
            fetchPc    <= rows[i].fetchPc;
            brValid    <= rows[i].brValid;
            brOffs     <= rows[i].brOffs;
            isCall     <= rows[i].isCall;
            setIdx     <= rows[i].setIdx;
            restoreIdx <= rows[i].restoreIdx;
            returnUpd  <= rows[i].returnUpd;
            @(negedge clk);
            checkIdx(i, curIdx, rows[i].expIdx);
            checkPred(i, predBr, rows[i].expPred);
            @(posedge clk);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: dv/tbClock.sv
// **************************************************
// Free-running testbench clock of period 4
// **************************************************

module tbClock (
    output logic clk
);
    localparam int HALF_PERIOD = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

// File: sim.f
design/fetchPkg.sv
design/retPredPkg.sv
design/retSiteTable.sv
design/retAddrStack.sv
design/retPredCtrl.sv
design/retPredUnit.sv
dv/tbClock.sv
dv/retPredTb.sv
